/* dft_defs.svh */
// width, stage count, table depth and credit macros for the dft parameter generator
`ifndef DFT_DEFS_SVH
`define DFT_DEFS_SVH

//--------------------------------------------------------------------------
// frame geometry
//--------------------------------------------------------------------------

// pipeline stages of the mixed-radix engine
`define DFT_NUM_STAGES 6

// dft length, strides and twiddle denominators all fit here
`define DFT_PTS_W 12

// one radix factor, values 1 to 5
`define DFT_FACTOR_W 3

// stage position and factor count
`define DFT_STAGE_W 3

//--------------------------------------------------------------------------
// size table and flow control
//--------------------------------------------------------------------------

// request selects one of the supported lengths
`define DFT_SIZE_IDX_W 3
`define DFT_NUM_SIZES 8

// downstream buffer slots for finished records
`define DFT_PARAM_CREDITS 2

// stage code when the length has no radix-2 pass
`define DFT_NO_RDX2 3'd7

`endif

/* dft_pkg.sv */
// shared enums and record structs of the dft parameter generator, imported by rtl and testbench
`default_nettype none

`include "dft_defs.svh"

package dft_pkg;

	//----------------------------------------------------------------------
	// enums
	//----------------------------------------------------------------------

	// butterfly radix, code equals the numeric factor
	typedef enum logic [`DFT_FACTOR_W-1:0] {
		RADIX_1 = 3'd1,
		RADIX_2 = 3'd2,
		RADIX_3 = 3'd3,
		RADIX_4 = 3'd4,
		RADIX_5 = 3'd5
	} radix_e;

	// controller phases
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_STRIDE,
		ST_CHAIN,
		ST_EMIT
	} ctrl_state_e;

	//----------------------------------------------------------------------
	// records
	//----------------------------------------------------------------------

	// one 12-bit word per stage
	typedef logic [`DFT_NUM_STAGES-1:0][`DFT_PTS_W-1:0] stage_vec_t;

	// one table entry, stage 0 is implied radix 4
	typedef struct packed {
		logic [`DFT_PTS_W-1:0]            pts;
		// N/15 if 5 divides N, else N/3
		logic [`DFT_PTS_W-1:0]            stride_base;
		logic                             factor_5;
		radix_e [`DFT_NUM_STAGES-1:1]     factor;
		logic [`DFT_STAGE_W-1:0]          num_factors;
		logic [`DFT_STAGE_W-1:0]          rdx2_stage;
	} size_rec_t;

	// finished parameter set sent downstream
	typedef struct packed {
		radix_e [`DFT_NUM_STAGES-1:0]     factor;
		logic [`DFT_STAGE_W-1:0]          num_factors;
		logic [`DFT_STAGE_W-1:0]          rdx2_stage;
		stage_vec_t                       stride;
		stage_vec_t                       denom;
	} dft_param_t;

endpackage

`default_nettype wire

/* size_rom.sv */
// registered size table, turns a size index into its factorization record one cycle after rd
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module size_rom import dft_pkg::*; (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        rd,
	input  wire logic [`DFT_SIZE_IDX_W-1:0]  size_idx,
	output size_rec_t                        rec
);

	// pack one entry, factors given for stages 1 to 5
	function automatic size_rec_t mk_rec(
		input logic [`DFT_PTS_W-1:0]   pts,
		input logic [`DFT_PTS_W-1:0]   base,
		input logic                    has5,
		input radix_e                  f1,
		input radix_e                  f2,
		input radix_e                  f3,
		input radix_e                  f4,
		input radix_e                  f5,
		input logic [`DFT_STAGE_W-1:0] nf,
		input logic [`DFT_STAGE_W-1:0] r2
	);
		size_rec_t r;
		r.pts         = pts;
		r.stride_base = base;
		r.factor_5    = has5;
		r.factor[1]   = f1;
		r.factor[2]   = f2;
		r.factor[3]   = f3;
		r.factor[4]   = f4;
		r.factor[5]   = f5;
		r.num_factors = nf;
		r.rdx2_stage  = r2;
		return r;
	endfunction

	//----------------------------------------------------------------------
	// greedy split 4,2,5,3 after the leading radix 4
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// empty record, all pad stages
			rec <= mk_rec('0, '0, 1'b0, RADIX_1, RADIX_1, RADIX_1, RADIX_1, RADIX_1,
				'0, `DFT_NO_RDX2);
		end else if (rd) begin
			case (size_idx)
				// 12 = 4*3
				3'd0: rec <= mk_rec(12'd12, 12'd4, 1'b0,
					RADIX_3, RADIX_1, RADIX_1, RADIX_1, RADIX_1, 3'd2, `DFT_NO_RDX2);
				// 60 = 4*5*3
				3'd1: rec <= mk_rec(12'd60, 12'd4, 1'b1,
					RADIX_5, RADIX_3, RADIX_1, RADIX_1, RADIX_1, 3'd3, `DFT_NO_RDX2);
				// 120 = 4*2*5*3, radix 2 in stage 1
				3'd2: rec <= mk_rec(12'd120, 12'd8, 1'b1,
					RADIX_2, RADIX_5, RADIX_3, RADIX_1, RADIX_1, 3'd4, 3'd1);
				3'd3: rec <= mk_rec(12'd240, 12'd16, 1'b1,
					RADIX_4, RADIX_5, RADIX_3, RADIX_1, RADIX_1, 3'd4, `DFT_NO_RDX2);
				3'd4: rec <= mk_rec(12'd300, 12'd20, 1'b1,
					RADIX_5, RADIX_5, RADIX_3, RADIX_1, RADIX_1, 3'd4, `DFT_NO_RDX2);
				// 480 = 4*4*2*5*3, radix 2 in stage 2
				3'd5: rec <= mk_rec(12'd480, 12'd32, 1'b1,
					RADIX_4, RADIX_2, RADIX_5, RADIX_3, RADIX_1, 3'd5, 3'd2);
				3'd6: rec <= mk_rec(12'd960, 12'd64, 1'b1,
					RADIX_4, RADIX_4, RADIX_5, RADIX_3, RADIX_1, 3'd5, `DFT_NO_RDX2);
				// largest frame
				3'd7: rec <= mk_rec(12'd1200, 12'd80, 1'b1,
					RADIX_4, RADIX_5, RADIX_5, RADIX_3, RADIX_1, 3'd5, `DFT_NO_RDX2);
			endcase
		end
	end

endmodule

`default_nettype wire

/* stride_calc.sv */
// per-stage butterfly stride N/factor from the size record, shift-and-add only, loaded on load
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module stride_calc import dft_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       load,
	input  wire size_rec_t  rec,
	output stage_vec_t      stride
);

	//----------------------------------------------------------------------
	// N / f without a divider
	//----------------------------------------------------------------------
	function automatic logic [`DFT_PTS_W-1:0] stride_of(
		input size_rec_t r,
		input radix_e    f
	);
		logic [`DFT_PTS_W-1:0] b;
		b = r.stride_base;
		case (f)
			RADIX_4: return r.pts >> 2;
			RADIX_2: return r.pts >> 1;
			// base is N/15 here, 3*N/15 = N/5
			RADIX_5: return b + (b << 1);
			// N/15*5 when 5 divides N, base already N/3 otherwise
			RADIX_3: return r.factor_5 ? b + (b << 2) : b;
			// pad stage
			default: return '0;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stride <= '0;
		end else if (load) begin
			// stage 0 fixed radix 4
			stride[0] <= stride_of(rec, RADIX_4);
			for (int k = 1; k < `DFT_NUM_STAGES; k++) begin
				stride[k] <= stride_of(rec, rec.factor[k]);
			end
		end
	end

endmodule

`default_nettype wire

/* twiddle_chain.sv */
// twiddle denominators as a backward product of factors, stage 4 down to 1, one stage per step
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module twiddle_chain import dft_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       step,
	input  wire size_rec_t  rec,
	output stage_vec_t      denom,
	output logic            done
);

	// steps taken in this sequence, wraps after stage 1
	logic [1:0]              cnt;
	logic [`DFT_STAGE_W-1:0] stage;
	logic [`DFT_PTS_W-1:0]   prod_in;
	radix_e                  fac;

	// x * r for the supported radices
	function automatic logic [`DFT_PTS_W-1:0] mul_radix(
		input logic [`DFT_PTS_W-1:0] x,
		input radix_e                r
	);
		case (r)
			RADIX_2: return x << 1;
			RADIX_3: return x + (x << 1);
			RADIX_4: return x << 2;
			RADIX_5: return x + (x << 2);
			default: return x;
		endcase
	endfunction

	//----------------------------------------------------------------------
	// chain position
	//----------------------------------------------------------------------

	// cnt 0..3 -> stage 4..1
	assign stage = 3'd4 - {1'b0, cnt};
	assign fac   = rec.factor[stage];

	// first step starts from the last factor itself
	assign prod_in = (cnt == 2'd0)
		? {{(`DFT_PTS_W-`DFT_FACTOR_W){1'b0}}, rec.factor[`DFT_NUM_STAGES-1]}
		: denom[stage + 3'd1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt  <= 2'd0;
			done <= 1'b0;
		end else if (step) begin
			cnt <= cnt + 2'd1;
			// cleared by the first step, set by the stage 1 write
			done <= (cnt == 2'd3);
		end
	end

	// running product, denom[k] = f[k]*...*f[5]
	always_ff @(posedge clk) begin
		if (step) begin
			if (cnt == 2'd0) begin
				denom[`DFT_NUM_STAGES-1] <= prod_in;
				// nothing precedes stage 0
				denom[0] <= rec.pts;
			end
			denom[stage] <= mul_radix(prod_in, fac);
		end
	end

endmodule

`default_nettype wire

/* param_ctrl.sv */
// request FSM of the generator, sequences lookup, strides and chain, then emits under credits
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module param_ctrl import dft_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       req_valid,
	output logic            req_ready,
	output logic            rom_rd,
	output logic            stride_load,
	output logic            chain_step,
	input  wire logic       chain_done,
	input  wire size_rec_t  rec,
	input  wire stage_vec_t stride,
	input  wire stage_vec_t denom,
	input  wire logic       credit_return,
	output logic            param_valid,
	output dft_param_t      param
);

	localparam int CRED_W = $clog2(`DFT_PARAM_CREDITS + 1);
	localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`DFT_PARAM_CREDITS);

	ctrl_state_e       state;
	ctrl_state_e       state_nxt;
	logic [CRED_W-1:0] credits;
	logic              emit_fire;

	//----------------------------------------------------------------------
	// strobes, one per phase
	//----------------------------------------------------------------------
	assign req_ready   = (state == ST_IDLE);
	// accept edge also latches the table entry
	assign rom_rd      = req_ready && req_valid;
	// record sits on the rom output during lookup
	assign stride_load = (state == ST_LOOKUP);
	// first step from stride phase, rest until the chain reports
	assign chain_step  = (state == ST_STRIDE) || (state == ST_CHAIN && !chain_done);
	assign emit_fire   = (state == ST_EMIT) && (credits != '0);

	always_comb begin
		state_nxt = state;
		unique case (state)
			ST_IDLE:   if (req_valid) state_nxt = ST_LOOKUP;
			ST_LOOKUP: state_nxt = ST_STRIDE;
			ST_STRIDE: state_nxt = ST_CHAIN;
			ST_CHAIN:  if (chain_done) state_nxt = ST_EMIT;
			// hold here while downstream is full
			ST_EMIT:   if (emit_fire) state_nxt = ST_IDLE;
			default:   state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			credits     <= CRED_MAX;
			param_valid <= 1'b0;
		end else begin
			state       <= state_nxt;
			param_valid <= emit_fire;
			// simultaneous spend and return cancel out
			case ({emit_fire, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= (credits == CRED_MAX) ? CRED_MAX : credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// output record, stable until the next emit
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (emit_fire) begin
			param.factor[0] <= RADIX_4;
			for (int k = 1; k < `DFT_NUM_STAGES; k++) begin
				param.factor[k] <= rec.factor[k];
			end
			param.num_factors <= rec.num_factors;
			param.rdx2_stage  <= rec.rdx2_stage;
			param.stride      <= stride;
			param.denom       <= denom;
		end
	end

endmodule

`default_nettype wire

/* param_gen_top.sv */
// top of the dft parameter generator, size table, stride and twiddle blocks around the FSM
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module param_gen_top import dft_pkg::*; (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        req_valid,
	input  wire logic [`DFT_SIZE_IDX_W-1:0]  req_size,
	output logic                             req_ready,
	output logic                             param_valid,
	output dft_param_t                       param,
	input  wire logic                        credit_return
);

	//----------------------------------------------------------------------
	// internal strobes and datapath results
	//----------------------------------------------------------------------
	logic       rom_rd;
	logic       stride_load;
	logic       chain_step;
	logic       chain_done;
	size_rec_t  rec;
	stage_vec_t stride;
	stage_vec_t denom;

	// index taken straight off the request bus at accept
	size_rom u_size_rom (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd       (rom_rd),
		.size_idx (req_size),
		.rec      (rec)
	);

	stride_calc u_stride_calc (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (stride_load),
		.rec    (rec),
		.stride (stride)
	);

	twiddle_chain u_twiddle_chain (
		.clk   (clk),
		.rst_n (rst_n),
		.step  (chain_step),
		.rec   (rec),
		.denom (denom),
		.done  (chain_done)
	);

	param_ctrl u_param_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.rom_rd        (rom_rd),
		.stride_load   (stride_load),
		.chain_step    (chain_step),
		.chain_done    (chain_done),
		.rec           (rec),
		.stride        (stride),
		.denom         (denom),
		.credit_return (credit_return),
		.param_valid   (param_valid),
		.param         (param)
	);

endmodule

`default_nettype wire

/* param_gen_sva.sv */
// handshake and credit assertions for the parameter FSM, bound into every param_ctrl instance
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module param_gen_sva (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req_valid,
	input wire logic req_ready,
	input wire logic credit_return,
	input wire logic param_valid
);

	localparam int CRED_W = $clog2(`DFT_PARAM_CREDITS + 1);
	localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`DFT_PARAM_CREDITS);

	// credits as seen from the result port
	logic [CRED_W-1:0] avail;
	// a request has been taken and not yet emitted
	logic              busy;

	//--------------------------------------------------------------------------
	// port-side bookkeeping
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			avail <= CRED_MAX;
			busy  <= 1'b0;
		end else begin
			// pulse spends one, return gives one back
			if (param_valid && !credit_return) begin
				avail <= avail - 1'b1;
			end else if (credit_return && !param_valid && avail != CRED_MAX) begin
				avail <= avail + 1'b1;
			end
			// a new accept on the emit cycle keeps it busy
			if (req_valid && req_ready) begin
				busy <= 1'b1;
			end else if (param_valid) begin
				busy <= 1'b0;
			end
		end
	end

	//--------------------------------------------------------------------------
	// credit and handshake rules
	//--------------------------------------------------------------------------

	// every pulse needs a credit left over from earlier returns
	a_no_credit_emit: assert property (@(posedge clk) disable iff (!rst_n)
		param_valid |-> (avail != '0))
		else $error("param_valid raised with no credit left");

	// no second accept while a frame is in flight
	a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && !param_valid) |-> !req_ready)
		else $error("req_ready high while a request is in flight");

	// single-cycle result strobe
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		param_valid |=> !param_valid)
		else $error("param_valid held longer than one cycle");

endmodule

bind param_ctrl param_gen_sva sva0 (
	.clk           (clk),
	.rst_n         (rst_n),
	.req_valid     (req_valid),
	.req_ready     (req_ready),
	.credit_return (credit_return),
	.param_valid   (param_valid)
);

`default_nettype wire

/* tb_param_gen.sv */
// directed testbench of the dft parameter generator, compiled with the sva bind as top level
`timescale 1ns/100ps
`default_nettype none

`include "dft_defs.svh"

module tb_param_gen import dft_pkg::*; ();

	localparam int NUM_TESTS  = 6;
	localparam int WAIT_LIMIT = 100;

	logic                       clk;
	logic                       rst_n;
	logic                       req_valid;
	logic [`DFT_SIZE_IDX_W-1:0] req_size;
	logic                       req_ready;
	logic                       param_valid;
	dft_param_t                 param;
	logic                       credit_return;

	integer seed;
	int     checks;
	int     errors;
	int     tests;
	int     test_err0;
	// records received but not yet handed back as credits
	int     owed;
	string  cur_test;

	param_gen_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_size      (req_size),
		.req_ready     (req_ready),
		.param_valid   (param_valid),
		.param         (param),
		.credit_return (credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// budget of 200 cycles per test
	initial begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	//--------------------------------------------------------------------------
	// reference model
	//--------------------------------------------------------------------------
	function automatic int pts_of(input int idx);
		case (idx)
			0: return 12;
			1: return 60;
			2: return 120;
			3: return 240;
			4: return 300;
			5: return 480;
			6: return 960;
			default: return 1200;
		endcase
	endfunction

	// greedy split 4,2,5,3, stage 0 always 4, pad with 1
	function automatic dft_param_t model_param(input int idx);
		dft_param_t p;
		int n;
		int rem;
		int prod;
		int f;
		int nf;
		int r2;
		n    = pts_of(idx);
		rem  = n;
		prod = 1;
		nf   = 0;
		r2   = 7;
		for (int k = 0; k < `DFT_NUM_STAGES; k++) begin
			if (k == 0 || rem % 4 == 0) f = 4;
			else if (rem % 2 == 0) f = 2;
			else if (rem % 5 == 0) f = 5;
			else if (rem % 3 == 0) f = 3;
			else f = 1;
			rem = rem / f;
			if (f != 1) nf++;
			if (f == 2 && r2 == 7) r2 = k;
			p.factor[k] = radix_e'(f);
			// pad stages carry no stride
			if (f == 1) p.stride[k] = '0;
			else p.stride[k] = `DFT_PTS_W'(n / f);
			// N over the product of all earlier factors
			p.denom[k] = `DFT_PTS_W'(n / prod);
			prod = prod * f;
		end
		p.num_factors = `DFT_STAGE_W'(nf);
		p.rdx2_stage  = `DFT_STAGE_W'(r2);
		return p;
	endfunction

	//--------------------------------------------------------------------------
	// checking and bookkeeping
	//--------------------------------------------------------------------------
	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_record(input int idx);
		dft_param_t e;
		e = model_param(idx);
		for (int k = 0; k < `DFT_NUM_STAGES; k++) begin
			check_value($sformatf("size %0d factor[%0d]", idx, k),
				32'(e.factor[k]), 32'(param.factor[k]));
			check_value($sformatf("size %0d stride[%0d]", idx, k),
				32'(e.stride[k]), 32'(param.stride[k]));
			check_value($sformatf("size %0d denom[%0d]", idx, k),
				32'(e.denom[k]), 32'(param.denom[k]));
		end
		check_value($sformatf("size %0d num_factors", idx),
			32'(e.num_factors), 32'(param.num_factors));
		check_value($sformatf("size %0d rdx2_stage", idx),
			32'(e.rdx2_stage), 32'(param.rdx2_stage));
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("%s finished with %0d errors", cur_test, errors - test_err0);
	endtask

	//--------------------------------------------------------------------------
	// stimulus, always entered and left on a falling edge
	//--------------------------------------------------------------------------

	// waits for req_ready, holds req_valid over one accept edge
	task automatic issue(input int idx);
		int n;
		n = 0;
		while (!req_ready && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!req_ready) begin
			errors++;
			$display("%s: req_ready stayed low, request for size %0d not taken", cur_test, idx);
		end
		req_valid = 1'b1;
		req_size  = `DFT_SIZE_IDX_W'(idx);
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic return_credit();
		credit_return = 1'b1;
		owed--;
		@(negedge clk);
		credit_return = 1'b0;
	endtask

	task automatic drain_credits();
		while (owed > 0) begin
			return_credit();
			@(negedge clk);
		end
	endtask

	// one chance in four per cycle to hand a credit back
	task automatic random_credit();
		integer r;
		r = $random(seed);
		if (owed > 0 && r[1:0] == 2'b00) begin
			credit_return = 1'b1;
			owed--;
		end else begin
			credit_return = 1'b0;
		end
	endtask

	// lat counts falling edges after the accept edge
	task automatic await_result(output int lat, input bit watch_ready, input bit rand_credit);
		lat = 0;
		while (!param_valid && lat < WAIT_LIMIT) begin
			if (watch_ready) check_value("req_ready while busy", 0, 32'(req_ready));
			if (rand_credit) random_credit();
			@(negedge clk);
			lat++;
		end
		credit_return = 1'b0;
		if (param_valid) begin
			owed++;
		end else begin
			errors++;
			$display("%s: no param_valid within %0d cycles", cur_test, WAIT_LIMIT);
		end
	endtask

	//--------------------------------------------------------------------------
	// tests
	//--------------------------------------------------------------------------
	task automatic test_reset();
		start_test("reset_state");
		check_value("req_ready", 1, 32'(req_ready));
		check_value("param_valid", 0, 32'(param_valid));
		end_test();
	endtask

	task automatic test_all_sizes();
		int lat;
		start_test("all_sizes");
		for (int i = 0; i < `DFT_NUM_SIZES; i++) begin
			issue(i);
			await_result(lat, 1'b0, 1'b0);
			check_record(i);
			return_credit();
		end
		end_test();
	endtask

	task automatic test_latency();
		int lat;
		int sizes[3];
		start_test("fixed_latency");
		sizes = '{0, 5, 7};
		foreach (sizes[i]) begin
			issue(sizes[i]);
			await_result(lat, 1'b0, 1'b0);
			check_value("accept to param_valid", 7, 32'(lat));
			check_record(sizes[i]);
			return_credit();
		end
		end_test();
	endtask

	task automatic test_credit_stall();
		int lat;
		start_test("credit_stall");
		// use up both credits
		issue(2);
		await_result(lat, 1'b0, 1'b0);
		check_record(2);
		issue(6);
		await_result(lat, 1'b0, 1'b0);
		check_record(6);
		issue(4);
		repeat (24) begin
			@(negedge clk);
			check_value("param_valid without credit", 0, 32'(param_valid));
		end
		return_credit();
		await_result(lat, 1'b0, 1'b0);
		check_record(4);
		drain_credits();
		end_test();
	endtask

	task automatic test_hold_off();
		int lat;
		start_test("request_hold_off");
		issue(1);
		// next request waits on the bus for the whole first frame
		req_valid = 1'b1;
		req_size  = 3'd5;
		await_result(lat, 1'b1, 1'b0);
		check_record(1);
		check_value("req_ready at emit", 1, 32'(req_ready));
		// second accept lands on this edge
		return_credit();
		req_valid = 1'b0;
		await_result(lat, 1'b0, 1'b0);
		check_value("held request latency", 7, 32'(lat));
		check_record(5);
		return_credit();
		end_test();
	endtask

	task automatic test_random();
		int lat;
		int idx;
		start_test("random_sequence");
		for (int i = 0; i < 12; i++) begin
			idx = $unsigned($random(seed)) % `DFT_NUM_SIZES;
			issue(idx);
			await_result(lat, 1'b0, 1'b1);
			check_record(idx);
		end
		@(negedge clk);
		drain_credits();
		end_test();
	endtask

	//--------------------------------------------------------------------------
	// main sequence
	//--------------------------------------------------------------------------
	initial begin
		seed          = 32'hfe3f;
		rst_n         = 1'b0;
		req_valid     = 1'b0;
		req_size      = '0;
		credit_return = 1'b0;
		checks        = 0;
		errors        = 0;
		tests         = 0;
		owed          = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_reset();
		test_all_sizes();
		test_latency();
		test_credit_stall();
		test_hold_off();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
dft_pkg.sv
size_rom.sv
stride_calc.sv
twiddle_chain.sv
param_ctrl.sv
param_gen_top.sv
param_gen_sva.sv
tb_param_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the parameter generator testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_param_gen \
	-f filelist.f -Mdir obj_dir -o tb_param_gen_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_param_gen_sim > sim.log 2>&1 || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
